// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= raster_front_tb
FILELIST ?= raster_front.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/batch_ctrl_if.sv ====
`default_nettype none

interface batch_ctrl_if;

    raster_pkg::tri_count_t tri_count; // triangles in the running batch.
    logic count_valid; // high from header capture until batch_done.
    logic slot_release; // one pulse per FIFO pop.
    logic batch_done; // one pulse when the last triangle has left setup.

    modport issue (
        input tri_count, count_valid, slot_release, batch_done
    );

    modport assemble (
        output tri_count, count_valid,
        input batch_done
    );

    modport setup (
        input tri_count, count_valid,
        output slot_release, batch_done
    );

endinterface

`default_nettype wire

// ==== hdl/raster_front.sv ====
`default_nettype none

`include "raster_params.svh"

module raster_front (
    input logic clock,
    input logic reset,
    input logic fetch_enable,
    input raster_pkg::addr_t base,
    output raster_pkg::addr_t address,
    output logic read,
    input raster_pkg::word_t readdata,
    input logic readdatavalid,
    input logic waitrequest,
    input logic stall,
    output logic tri_valid,
    output raster_pkg::triangle_t tri_out,
    output raster_pkg::coord_t bbox_min_x,
    output raster_pkg::coord_t bbox_min_y,
    output raster_pkg::coord_t bbox_max_x,
    output raster_pkg::coord_t bbox_max_y,
    output raster_pkg::area_t area,
    output logic done
);

    import raster_pkg::*;

    logic tri_wr;
    triangle_t tri_data;
    logic tri_rd;
    triangle_t fifo_data;
    logic fifo_empty;

    batch_ctrl_if ctrl_bus ();

    vertex_read_issue i_issue (
        .clock(clock),
        .reset(reset),
        .fetch_enable(fetch_enable),
        .base(base),
        .address(address),
        .read(read),
        .waitrequest(waitrequest),
        .ctrl(ctrl_bus.issue)
    );

    vertex_assemble i_assemble (
        .clock(clock),
        .reset(reset),
        .readdata(readdata),
        .readdatavalid(readdatavalid),
        .tri_wr(tri_wr),
        .tri_data(tri_data),
        .ctrl(ctrl_bus.assemble)
    );

    tri_fifo #(
        .log2_depth(`RASTER_FIFO_LOG2)
    ) i_fifo (
        .clock(clock),
        .reset(reset),
        .wr(tri_wr),
        .wr_data(tri_data),
        .rd(tri_rd),
        .rd_data(fifo_data),
        .empty(fifo_empty)
    );

    tri_setup i_setup (
        .clock(clock),
        .reset(reset),
        .stall(stall),
        .tri_rd(tri_rd),
        .empty(fifo_empty),
        .rd_data(fifo_data),
        .tri_valid(tri_valid),
        .tri_out(tri_out),
        .bbox_min_x(bbox_min_x),
        .bbox_min_y(bbox_min_y),
        .bbox_max_x(bbox_max_x),
        .bbox_max_y(bbox_max_y),
        .area(area),
        .done(done),
        .ctrl(ctrl_bus.setup)
    );

endmodule

`default_nettype wire

// ==== hdl/raster_pkg.sv ====
`default_nettype none

`include "raster_params.svh"

package raster_pkg;

    // one byte address on the read master.
    typedef logic [`RASTER_ADDR_BITS-1:0] addr_t;

    typedef logic [31:0] word_t;

    // the header word is cut down to this width.
    typedef logic [15:0] tri_count_t;

    // word 0 sits in the low bits.
    typedef logic [`RASTER_TRI_WORDS*32-1:0] triangle_t;

    // integer part of an x or y word.
    typedef logic signed [15:0] coord_t;

    // doubled signed area of a triangle.
    typedef logic signed [33:0] area_t;

    typedef enum logic [1:0] {
        idle,
        header,
        words,
        drain
    } issue_state_t;

    typedef enum logic {
        wait_count,
        collect
    } assemble_state_t;

endpackage

`default_nettype wire

// ==== hdl/tri_fifo.sv ====
`default_nettype none

`include "raster_params.svh"

module tri_fifo #(
    parameter int log2_depth = `RASTER_FIFO_LOG2
) (
    input logic clock,
    input logic reset,
    input logic wr,
    input raster_pkg::triangle_t wr_data,
    input logic rd,
    output raster_pkg::triangle_t rd_data,
    output logic empty
);

    import raster_pkg::*;

    localparam int depth = 1 << log2_depth;

    triangle_t mem [depth];
    logic [log2_depth-1:0] wr_ptr;
    logic [log2_depth-1:0] rd_ptr;
    logic [log2_depth:0] count;

    assign empty = (count == '0);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at the depth.
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr && !rd) begin
                count <= count + 1'b1;
            end else if (!wr && rd) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd) begin
            rd_data <= mem[rd_ptr]; // valid the cycle after rd.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tri_setup.sv ====
`default_nettype none

module tri_setup (
    input logic clock,
    input logic reset,
    input logic stall,
    output logic tri_rd,
    input logic empty,
    input raster_pkg::triangle_t rd_data,
    output logic tri_valid,
    output raster_pkg::triangle_t tri_out,
    output raster_pkg::coord_t bbox_min_x,
    output raster_pkg::coord_t bbox_min_y,
    output raster_pkg::coord_t bbox_max_x,
    output raster_pkg::coord_t bbox_max_y,
    output raster_pkg::area_t area,
    output logic done,
    batch_ctrl_if.setup ctrl
);

    import raster_pkg::*;

    function automatic coord_t int_part(triangle_t t, int unsigned w);
        return coord_t'(t[w*32+16 +: 16]);
    endfunction

    function automatic coord_t min3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic coord_t max3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    logic popped; // rd_data holds a fresh triangle this cycle.
    tri_count_t consumed;
    coord_t x0, x1, x2, y0, y1, y2;
    area_t area_next;

    // the gap after each pop lets empty settle before the next one.
    assign tri_rd = !stall && !empty && !popped;
    assign ctrl.slot_release = tri_rd;
    assign ctrl.batch_done = done;

    always_comb begin
        x0 = int_part(rd_data, 0);
        y0 = int_part(rd_data, 1);
        x1 = int_part(rd_data, 5);
        y1 = int_part(rd_data, 6);
        x2 = int_part(rd_data, 10);
        y2 = int_part(rd_data, 11);
        area_next = (area_t'(x1) - area_t'(x0)) * (area_t'(y2) - area_t'(y0)) -
                    (area_t'(x2) - area_t'(x0)) * (area_t'(y1) - area_t'(y0));
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            popped <= 1'b0;
            tri_valid <= 1'b0;
            consumed <= '0;
            done <= 1'b0;
        end else begin
            popped <= tri_rd;
            tri_valid <= popped && (area_next != '0); // degenerate triangles are dropped here.
            done <= !done && ctrl.count_valid && (consumed == ctrl.tri_count);
            if (done) begin
                consumed <= '0;
            end else if (popped) begin
                consumed <= consumed + tri_count_t'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (popped) begin
            tri_out <= rd_data;
            bbox_min_x <= min3(x0, x1, x2);
            bbox_min_y <= min3(y0, y1, y2);
            bbox_max_x <= max3(x0, x1, x2);
            bbox_max_y <= max3(y0, y1, y2);
            area <= area_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/vertex_assemble.sv ====
`default_nettype none

module vertex_assemble (
    input logic clock,
    input logic reset,
    input raster_pkg::word_t readdata,
    input logic readdatavalid,
    output logic tri_wr,
    output raster_pkg::triangle_t tri_data,
    batch_ctrl_if.assemble ctrl
);

    import raster_pkg::*;

    assemble_state_t state;
    logic [3:0] word_idx; // slot for the next returned word.
    logic word_in;

    assign word_in = (state == collect) && readdatavalid;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= wait_count;
            ctrl.count_valid <= 1'b0;
            ctrl.tri_count <= '0;
            word_idx <= '0;
            tri_wr <= 1'b0;
        end else begin
            tri_wr <= word_in && (word_idx == 4'd14);
            case (state)
                wait_count: begin
                    if (readdatavalid) begin
                        ctrl.tri_count <= readdata[15:0]; // upper half of the header is ignored.
                        ctrl.count_valid <= 1'b1;
                        word_idx <= '0;
                        state <= collect;
                    end
                end
                collect: begin
                    if (readdatavalid) begin
                        if (word_idx == 4'd14) begin
                            word_idx <= '0;
                        end else begin
                            word_idx <= word_idx + 4'd1;
                        end
                    end
                    if (ctrl.batch_done) begin
                        ctrl.count_valid <= 1'b0;
                        state <= wait_count;
                    end
                end
                default: state <= wait_count;
            endcase
        end
    end

    // the FIFO samples the old contents on the edge that a new word overwrites them.
    always_ff @(posedge clock) begin
        if (word_in) begin
            tri_data[word_idx*32 +: 32] <= readdata;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/vertex_read_issue.sv ====
`default_nettype none

`include "raster_params.svh"

module vertex_read_issue (
    input logic clock,
    input logic reset,
    input logic fetch_enable,
    input raster_pkg::addr_t base,
    output raster_pkg::addr_t address,
    output logic read,
    input logic waitrequest,
    batch_ctrl_if.issue ctrl
);

    import raster_pkg::*;

    localparam int unsigned fifo_depth = 1 << `RASTER_FIFO_LOG2;

    issue_state_t state;
    logic [3:0] word_idx; // word of the current triangle being requested.
    tri_count_t started; // triangles whose reads have begun.
    logic [`RASTER_FIFO_LOG2:0] credits; // started triangles still holding a slot.
    logic accepted;
    logic can_start;
    logic start_tri;

    assign accepted = read && !waitrequest;

    assign can_start = ctrl.count_valid && (started != ctrl.tri_count) &&
                       (credits < fifo_depth);

    // a triangle starts from a quiet bus or straight after the previous one's last word.
    assign start_tri = (state == words) && can_start &&
                       (!read || (accepted && word_idx == 4'd14));

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= idle;
            read <= 1'b0;
            address <= '0;
            word_idx <= '0;
            started <= '0;
        end else begin
            case (state)
                idle: begin
                    if (fetch_enable) begin
                        address <= base;
                        read <= 1'b1;
                        started <= '0;
                        word_idx <= '0;
                        state <= header;
                    end
                end
                header: begin
                    if (!waitrequest) begin
                        read <= 1'b0;
                        address <= address + addr_t'(4);
                        state <= words;
                    end
                end
                words: begin
                    if (accepted) begin
                        address <= address + addr_t'(4); // address always points at the next word.
                        if (word_idx == 4'd14) begin
                            word_idx <= '0;
                            read <= start_tri;
                        end else begin
                            word_idx <= word_idx + 4'd1;
                        end
                    end else if (!read) begin
                        if (start_tri) begin
                            read <= 1'b1;
                        end else if (ctrl.count_valid && started == ctrl.tri_count) begin
                            state <= drain; // every triangle has been requested.
                        end
                    end
                    if (start_tri) begin
                        started <= started + tri_count_t'(1);
                    end
                end
                drain: begin
                    if (ctrl.batch_done) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // a slot is taken when a triangle starts and given back when setup pops one.
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            credits <= '0;
        end else if (start_tri && !ctrl.slot_release) begin
            credits <= credits + 1'b1;
        end else if (!start_tri && ctrl.slot_release) begin
            credits <= credits - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== include/raster_params.svh ====
`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// byte address width on the memory side.
`define RASTER_ADDR_BITS 26

// three vertices of x, y, z, colour and a spare word.
`define RASTER_TRI_WORDS 15

// the FIFO holds 2**RASTER_FIFO_LOG2 whole triangles.
`define RASTER_FIFO_LOG2 2

`endif

// ==== raster_front.f ====
+incdir+include
hdl/raster_pkg.sv
hdl/batch_ctrl_if.sv
hdl/vertex_read_issue.sv
hdl/vertex_assemble.sv
hdl/tri_fifo.sv
hdl/tri_setup.sv
hdl/raster_front.sv
verif/raster_front_asserts.sv
verif/raster_front_tb.sv

// ==== verif/raster_front_asserts.sv ====
`default_nettype none

module raster_front_asserts (
    input logic clock,
    input logic reset,
    input raster_pkg::addr_t address,
    input logic read,
    input logic waitrequest,
    input logic readdatavalid,
    input logic tri_valid,
    input logic done
);

    int addr_fails = 0;
    int reset_fails = 0;
    int return_fails = 0;
    int done_fails = 0;
    logic [7:0] outstanding; // reads accepted but not yet returned.
    logic done_seen; // done has pulsed and no read has begun the next batch.

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            outstanding <= '0;
            done_seen <= 1'b0;
        end else begin
            outstanding <= outstanding + 8'(read && !waitrequest) - 8'(readdatavalid);
            if (done) begin
                done_seen <= 1'b1;
            end else if (read) begin
                done_seen <= 1'b0;
            end
        end
    end

    address_held: assert property (@(posedge clock) disable iff (!reset)
        read && waitrequest |=> read && $stable(address))
    else begin
        addr_fails++;
        $error("read request changed while waitrequest was high");
    end

    quiet_in_reset: assert property (@(posedge clock) !reset |-> !tri_valid && !done)
    else begin
        reset_fails++;
        $error("tri_valid or done high during reset");
    end

    no_extra_data: assert property (@(posedge clock) disable iff (!reset)
        readdatavalid |-> outstanding != 0)
    else begin
        return_fails++;
        $error("readdatavalid without an outstanding read");
    end

    done_pulse: assert property (@(posedge clock) disable iff (!reset) done |-> !done_seen)
    else begin
        done_fails++;
        $error("done pulsed again before a new batch began");
    end

endmodule

`default_nettype wire

// ==== verif/raster_front_tb.sv ====
`default_nettype none

module raster_front_tb;

    import raster_pkg::*;

    typedef struct packed {
        triangle_t tri_v;
        coord_t min_x;
        coord_t min_y;
        coord_t max_x;
        coord_t max_y;
        area_t twice_area;
    } expect_t;

    localparam int mem_words = 4096;

    logic clock;
    logic reset;
    logic fetch_enable;
    addr_t base;
    addr_t address;
    logic read;
    word_t readdata = '0;
    logic readdatavalid = 1'b0;
    logic waitrequest = 1'b0;
    logic stall = 1'b0;
    logic tri_valid;
    triangle_t tri_out;
    coord_t bbox_min_x;
    coord_t bbox_min_y;
    coord_t bbox_max_x;
    coord_t bbox_max_y;
    area_t area;
    logic done;

    word_t mem [mem_words];
    expect_t exp_q [$];
    word_t rdata_q [$];
    int due_q [$]; // cycle at which each queued word may return.
    logic [31:0] rng_state = 32'h3fb49344;
    int cycle = 0;
    int limit = 0;
    int checks = 0;
    int errors = 0;
    int done_count = 0;
    int reads_accepted = 0;
    int emitted = 0;
    addr_t next_addr = '0;
    logic stall_enable = 1'b0;
    int stall_hold = 0;
    int stall_outputs = 0;
    int counts [3];

    raster_front i_dut (.*);

    bind raster_front raster_front_asserts i_asserts (
        .clock(clock),
        .reset(reset),
        .address(address),
        .read(read),
        .waitrequest(waitrequest),
        .readdatavalid(readdatavalid),
        .tri_valid(tri_valid),
        .done(done)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // 12-bit signed integer part keeps the area far from overflow.
    function automatic word_t random_coord_word();
        logic [31:0] r;
        r = next_random();
        return {{4{r[27]}}, r[27:16], r[15:0]};
    endfunction

    task automatic report_mismatch(input string name, input logic [479:0] expected,
                                   input logic [479:0] actual);
        errors++;
        $display("ERROR %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("ERROR %0t: %s", $time, what);
    endtask

    task automatic build_batch(input addr_t b, input int count);
        int w;
        int i;
        logic [31:0] r;
        w = int'(b >> 2);
        r = next_random();
        mem[w] = {r[31:16], count[15:0]}; // the upper half is noise.
        for (i = 0; i < count * 15; i++) begin
            if (i % 5 < 2) begin
                mem[w + 1 + i] = random_coord_word();
            end else begin
                mem[w + 1 + i] = next_random();
            end
        end
        for (i = 0; i < count; i++) begin
            if (next_random() % 4 == 0) begin
                mem[w + 1 + i * 15 + 10] = mem[w + 1 + i * 15]; // vertex 2 repeats vertex 0.
                mem[w + 1 + i * 15 + 11] = mem[w + 1 + i * 15 + 1];
            end
        end
    endtask

    task automatic model_batch(input addr_t b, input int count);
        int w;
        expect_t e;
        longint x [3];
        longint y [3];
        longint a;
        longint mnx;
        longint mny;
        longint mxx;
        longint mxy;
        for (int t = 0; t < count; t++) begin
            w = int'(b >> 2) + 1 + t * 15;
            for (int k = 0; k < 15; k++) begin
                e.tri_v[k*32 +: 32] = mem[w + k];
            end
            for (int v = 0; v < 3; v++) begin
                x[v] = longint'(coord_t'(mem[w + 5 * v][31:16]));
                y[v] = longint'(coord_t'(mem[w + 5 * v + 1][31:16]));
            end
            a = (x[1] - x[0]) * (y[2] - y[0]) - (x[2] - x[0]) * (y[1] - y[0]);
            mnx = x[0];
            mxx = x[0];
            mny = y[0];
            mxy = y[0];
            for (int v = 1; v < 3; v++) begin
                if (x[v] < mnx) mnx = x[v];
                if (x[v] > mxx) mxx = x[v];
                if (y[v] < mny) mny = y[v];
                if (y[v] > mxy) mxy = y[v];
            end
            e.min_x = coord_t'(mnx);
            e.min_y = coord_t'(mny);
            e.max_x = coord_t'(mxx);
            e.max_y = coord_t'(mxy);
            e.twice_area = area_t'(a);
            if (a != 0) exp_q.push_back(e);
        end
    endtask

    // the memory model, output monitor and stall source all run on the falling edge.
    always @(negedge clock) begin
        expect_t e;
        cycle++;
        if (reset && tri_valid) begin
            emitted++;
            checks++;
            if (area == '0) report_failure("a degenerate triangle reached the output");
            if (exp_q.size() == 0) begin
                report_failure("tri_valid with no triangle left in the model");
            end else begin
                e = exp_q.pop_front();
                if (tri_out !== e.tri_v) report_mismatch("tri_out", e.tri_v, tri_out);
                if (bbox_min_x !== e.min_x) begin
                    report_mismatch("bbox_min_x", 480'(e.min_x), 480'(bbox_min_x));
                end
                if (bbox_min_y !== e.min_y) begin
                    report_mismatch("bbox_min_y", 480'(e.min_y), 480'(bbox_min_y));
                end
                if (bbox_max_x !== e.max_x) begin
                    report_mismatch("bbox_max_x", 480'(e.max_x), 480'(bbox_max_x));
                end
                if (bbox_max_y !== e.max_y) begin
                    report_mismatch("bbox_max_y", 480'(e.max_y), 480'(bbox_max_y));
                end
                if (area !== e.twice_area) report_mismatch("area", 480'(e.twice_area), 480'(area));
            end
            if (stall) begin
                stall_outputs++;
                if (stall_outputs > 1) report_failure("more than one tri_valid after stall rose");
            end
        end
        if (reset && done) begin
            done_count++;
            checks++;
            if (exp_q.size() != 0) report_failure("done came before all triangles were emitted");
        end
        readdatavalid = 1'b0;
        if (rdata_q.size() != 0 && due_q[0] <= cycle) begin
            readdatavalid = 1'b1;
            readdata = rdata_q.pop_front();
            void'(due_q.pop_front());
        end
        waitrequest = (next_random() % 10) < 3;
        if (read && !waitrequest) begin
            checks++;
            if (address !== next_addr) report_mismatch("address", 480'(next_addr), 480'(address));
            reads_accepted++;
            next_addr = next_addr + addr_t'(4);
            rdata_q.push_back(mem[address[13:2]]);
            due_q.push_back(cycle + 1 + int'(next_random() % 4));
        end
        if (stall) begin
            stall_hold--;
            if (stall_hold <= 0) stall = 1'b0;
        end else if (stall_enable && next_random() % 12 == 0) begin
            stall = 1'b1;
            stall_hold = 30 + int'(next_random() % 90); // long enough to fill the FIFO.
            stall_outputs = 0;
        end
    end

    task automatic run_batch(input string name, input addr_t b, input int count,
                             input logic with_stall, input logic second_fetch);
        int done_before;
        int errors_before;
        int emitted_before;
        model_batch(b, count);
        next_addr = b;
        reads_accepted = 0;
        done_before = done_count;
        errors_before = errors;
        emitted_before = emitted;
        stall_enable = with_stall;
        @(negedge clock);
        fetch_enable = 1'b1;
        base = b;
        @(negedge clock);
        fetch_enable = 1'b0;
        if (second_fetch) begin
            repeat (20) @(negedge clock);
            fetch_enable = 1'b1; // the busy front end must ignore this one.
            base = b + addr_t'(32'h800);
            @(negedge clock);
            fetch_enable = 1'b0;
        end
        while (done_count == done_before) @(negedge clock);
        stall_enable = 1'b0;
        repeat (30) @(negedge clock);
        checks += 3;
        if (done_count != done_before + 1) report_failure("done did not pulse exactly once");
        if (reads_accepted != 1 + 15 * count) begin
            report_mismatch("accepted reads", 480'(1 + 15 * count), 480'(reads_accepted));
        end
        if (exp_q.size() != 0) report_failure("expected triangles never arrived");
        $display("test %s: %0d triangles, %0d emitted, %0d errors", name, count,
                 emitted - emitted_before, errors - errors_before);
    endtask

    initial begin
        wait (limit != 0);
        while (cycle < limit) @(posedge clock);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        fetch_enable = 1'b0;
        base = '0;
        reset = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = next_random();
        end
        counts[0] = 3 + int'(next_random() % 6);
        counts[1] = 0;
        counts[2] = 4 + int'(next_random() % 5);
        build_batch(addr_t'(32'h100), counts[0]);
        build_batch(addr_t'(32'h1000), counts[1]);
        build_batch(addr_t'(32'h2000), counts[2]);
        limit = 400 * (counts[0] + counts[1] + counts[2]) + 2000;
        repeat (16) @(negedge clock);
        reset = 1'b1;
        run_batch("basic_batch", addr_t'(32'h100), counts[0], 1'b0, 1'b0);
        run_batch("empty_batch", addr_t'(32'h1000), counts[1], 1'b0, 1'b0);
        run_batch("stall_batch", addr_t'(32'h2000), counts[2], 1'b1, 1'b1);
        errors += i_dut.i_asserts.addr_fails + i_dut.i_asserts.reset_fails +
                  i_dut.i_asserts.return_fails + i_dut.i_asserts.done_fails;
        $display("tests 3, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
